// File: include/game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Chart storage
`define CHART_LEN 16
`define CHART_AW 4

// Step and sample timing in prog_clk cycles
`define STEP_CYCLES 64
`define SAMPLE_CYCLES 32

// Steps each countdown digit is shown
`define COUNT_STEPS 2

// Middle octave tone half-periods in cycles
`define HALF_C 3
`define HALF_D 4
`define HALF_E 5
`define HALF_F 6
`define HALF_G 7
`define HALF_A 8
`define HALF_B 9

// Points per timing window position
`define PTS_EXACT 10
`define PTS_NEAR 8
`define PTS_LATE 5

`define SCORE_W 14

`endif

// File: design/game_pkg.sv
`include "game_settings.svh"

package game_pkg;

    // Value 2'b11 is not a legal octave
    typedef enum logic [1:0] {
        OCT_MID  = 2'b00,
        OCT_LOW  = 2'b01,
        OCT_HIGH = 2'b10
    } octave_t;

    // Key is one-hot, C in bit 0 up to B in bit 6
    typedef struct packed {
        octave_t    oct;
        logic [6:0] key;
    } note_fields_t;

    // Stored and compared as a word, decoded through fields
    typedef union packed {
        logic [8:0]   raw;
        note_fields_t fields;
    } note_t;

    // Wraps on overflow
    typedef logic [`SCORE_W-1:0] score_t;

    // Anything that is not a single key in a legal octave is a rest
    function automatic logic note_valid(note_t n);
        return (n.fields.oct != 2'b11) && $onehot(n.fields.key);
    endfunction

endpackage

// File: design/chart_mem.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module chart_mem (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  logic                 chart_wr_en,
    input  logic [`CHART_AW-1:0] chart_wr_addr,
    input  game_pkg::note_t      chart_wr_note,
    input  logic [`CHART_AW-1:0] read_addr,
    output game_pkg::note_t      read_note
);
    import game_pkg::*;

    note_t mem [`CHART_LEN];

    // Write lands at the strobe edge
    always_ff @(posedge prog_clk) begin
        if (chart_wr_en) begin
            mem[chart_wr_addr] <= chart_wr_note;
        end
    end

    // Read data follows the address by one cycle
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            read_note <= '0;
        end else begin
            read_note <= mem[read_addr];
        end
    end

endmodule

// File: design/beat_timer.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module beat_timer (
    input  logic       prog_clk,
    input  logic       rst,
    output logic       step_tick,
    output logic       sample_tick,
    output logic [1:0] count_digit,
    output logic       playing
);
    localparam int CYC_W = $clog2(`STEP_CYCLES);
    localparam int DIG_W = $clog2(`COUNT_STEPS + 1);

    logic [CYC_W-1:0] cyc_cnt;
    logic [DIG_W-1:0] dig_steps;
    logic             step_end;
    logic             half_end;

    // Last cycle of a step and of its first half
    assign step_end = (cyc_cnt == CYC_W'(`STEP_CYCLES - 1));
    assign half_end = (cyc_cnt == CYC_W'(`SAMPLE_CYCLES - 1));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cyc_cnt     <= '0;
            step_tick   <= 1'b0;
            sample_tick <= 1'b0;
        end else begin
            cyc_cnt     <= step_end ? '0 : cyc_cnt + 1'b1;
            step_tick   <= step_end;
            sample_tick <= step_end | half_end;
        end
    end

    // Countdown 3 to 0, then play
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            dig_steps   <= '0;
            count_digit <= 2'd3;
            playing     <= 1'b0;
        end else if (step_tick && !playing) begin
            if (dig_steps == DIG_W'(`COUNT_STEPS - 1)) begin
                dig_steps <= '0;
                if (count_digit == 2'd0) begin
                    playing <= 1'b1;
                end else begin
                    count_digit <= count_digit - 2'd1;
                end
            end else begin
                dig_steps <= dig_steps + 1'b1;
            end
        end
    end

    // Digit moves down by one at most while waiting, never wrapping
    assert property (@(posedge prog_clk) disable iff (rst)
        !playing |=> (count_digit == $past(count_digit)) ||
                     ($past(count_digit) != 2'd0 &&
                      count_digit == $past(count_digit) - 2'd1));

endmodule

// File: design/note_sequencer.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module note_sequencer (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  logic                 step_tick,
    input  logic                 playing,
    input  logic [`CHART_AW:0]   chart_len,
    output logic [`CHART_AW-1:0] read_addr,
    input  game_pkg::note_t      read_note,
    output game_pkg::note_t      cur_note,
    output logic                 done
);
    // One bit wider than the address so a full chart can be counted
    logic [`CHART_AW:0] idx;
    logic [`CHART_AW:0] idx_next;
    logic               advance;

    assign advance   = step_tick && playing && !done;
    assign idx_next  = idx + 1'b1;
    assign read_addr = idx[`CHART_AW-1:0];

    // Index and end of chart
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            idx  <= '0;
            done <= 1'b0;
        end else if (advance) begin
            idx <= idx_next;
            if (idx_next == chart_len) begin
                done <= 1'b1;
            end
        end
    end

    // Read data already points at idx, so load it on the tick
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cur_note <= '0;
        end else if (advance) begin
            cur_note <= read_note;
        end
    end

    // Holds until the next reset
    assert property (@(posedge prog_clk) disable iff (rst)
        done |=> done);

endmodule

// File: design/hit_scorer.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module hit_scorer (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             sample_tick,
    input  logic             playing,
    input  logic             done,
    input  game_pkg::note_t  cur_note,
    input  game_pkg::note_t  key_in,
    output game_pkg::score_t score
);
    import game_pkg::*;

    // hist[0] is the previous sample, hist[2] the oldest
    note_t  hist [3];
    score_t points;
    logic   active;

    assign active = sample_tick && playing && !done;

    // Earliest match in the window wins
    always_comb begin
        points = '0;
        if (note_valid(cur_note)) begin
            if (cur_note.raw == key_in.raw || cur_note.raw == hist[0].raw) begin
                points = score_t'(`PTS_EXACT);
            end else if (cur_note.raw == hist[1].raw) begin
                points = score_t'(`PTS_NEAR);
            end else if (cur_note.raw == hist[2].raw) begin
                points = score_t'(`PTS_LATE);
            end
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            hist[0] <= '0;
            hist[1] <= '0;
            hist[2] <= '0;
        end else if (active) begin
            hist[0] <= key_in;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
        end else if (active) begin
            score <= score + points;
        end
    end

    // Score moves only right after a sample
    assert property (@(posedge prog_clk) disable iff (rst)
        !sample_tick |=> $stable(score));

endmodule

// File: design/note_output.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module note_output (
    input  logic            prog_clk,
    input  logic            rst,
    input  game_pkg::note_t cur_note,
    output logic            tone,
    output logic [7:0]      led
);
    import game_pkg::*;

    localparam int HP_W = $clog2(2 * `HALF_B + 1);

    logic [HP_W-1:0] mid_half;
    logic [HP_W-1:0] half;
    logic [HP_W-1:0] hp_cnt;
    logic [7:0]      led_next;
    logic            valid;
    note_t           note_q;

    assign valid = note_valid(cur_note);

    always_comb begin
        case (cur_note.fields.key)
            7'b0000001: mid_half = HP_W'(`HALF_C);
            7'b0000010: mid_half = HP_W'(`HALF_D);
            7'b0000100: mid_half = HP_W'(`HALF_E);
            7'b0001000: mid_half = HP_W'(`HALF_F);
            7'b0010000: mid_half = HP_W'(`HALF_G);
            7'b0100000: mid_half = HP_W'(`HALF_A);
            7'b1000000: mid_half = HP_W'(`HALF_B);
            default:    mid_half = '0;
        endcase
    end

    // High octave halves the period, low doubles it
    always_comb begin
        case (cur_note.fields.oct)
            OCT_HIGH: half = mid_half >> 1;
            OCT_LOW:  half = mid_half << 1;
            default:  half = mid_half;
        endcase
    end

    // Key C on led[7] down to B on led[1]
    always_comb begin
        led_next = '0;
        if (valid) begin
            led_next[0] = (cur_note.fields.oct != OCT_MID);
            for (int i = 0; i < 7; i++) begin
                led_next[7 - i] = cur_note.fields.key[i];
            end
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_q <= '0;
            hp_cnt <= '0;
            tone   <= 1'b0;
            led    <= '0;
        end else begin
            note_q <= cur_note;
            led    <= led_next;
            if (!valid) begin
                hp_cnt <= '0;
                tone   <= 1'b0;
            end else if (cur_note.raw != note_q.raw) begin
                hp_cnt <= '0;
            end else if (hp_cnt == half - 1'b1) begin
                hp_cnt <= '0;
                tone   <= ~tone;
            end else begin
                hp_cnt <= hp_cnt + 1'b1;
            end
        end
    end

    // At most one key lamp
    assert property (@(posedge prog_clk) disable iff (rst)
        $onehot0(led[7:1]));

endmodule

// File: design/game_top.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module game_top (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  logic                 chart_wr_en,
    input  logic [`CHART_AW-1:0] chart_wr_addr,
    input  game_pkg::note_t      chart_wr_note,
    input  logic [`CHART_AW:0]   chart_len,
    input  game_pkg::note_t      key_in,
    output logic [1:0]           count_digit,
    output logic                 playing,
    output logic                 done,
    output game_pkg::note_t      cur_note,
    output game_pkg::score_t     score,
    output logic                 tone,
    output logic [7:0]           led
);
    import game_pkg::*;

    logic                 step_tick;
    logic                 sample_tick;
    logic [`CHART_AW-1:0] read_addr;
    note_t                read_note;

    chart_mem i_chart_mem (
        .prog_clk      (prog_clk),
        .rst           (rst),
        .chart_wr_en   (chart_wr_en),
        .chart_wr_addr (chart_wr_addr),
        .chart_wr_note (chart_wr_note),
        .read_addr     (read_addr),
        .read_note     (read_note)
    );

    beat_timer i_beat_timer (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .step_tick   (step_tick),
        .sample_tick (sample_tick),
        .count_digit (count_digit),
        .playing     (playing)
    );

    note_sequencer i_note_sequencer (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .step_tick (step_tick),
        .playing   (playing),
        .chart_len (chart_len),
        .read_addr (read_addr),
        .read_note (read_note),
        .cur_note  (cur_note),
        .done      (done)
    );

    hit_scorer i_hit_scorer (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .playing     (playing),
        .done        (done),
        .cur_note    (cur_note),
        .key_in      (key_in),
        .score       (score)
    );

    note_output i_note_output (
        .prog_clk (prog_clk),
        .rst      (rst),
        .cur_note (cur_note),
        .tone     (tone),
        .led      (led)
    );

endmodule

// File: verif/game_tb_tasks.svh
`ifndef GAME_TB_TASKS_SVH
`define GAME_TB_TASKS_SVH

task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
endtask

task automatic compare_note(input string name, input note_t got, input note_t exp);
    if (got.raw !== exp.raw) begin
        fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got.raw, exp.raw));
    end
endtask

task automatic compare_score(input string name, input score_t got, input score_t exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic compare_bits(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
endtask

// A single key in a legal octave
function automatic logic is_playable(input note_t n);
    return (n.raw[8:7] != 2'b11) && ($countones(n.fields.key) == 1);
endfunction

// Octave flag low, keys reversed on top
function automatic logic [7:0] led_rule(input note_t n);
    logic [7:0] l;
    l = '0;
    if (is_playable(n)) begin
        l[0]   = (n.fields.oct == OCT_HIGH) || (n.fields.oct == OCT_LOW);
        l[7:1] = {<<{n.fields.key}};
    end
    return l;
endfunction

function automatic int half_rule(input note_t n);
    int mids [7];
    int mid;
    mids = '{`HALF_C, `HALF_D, `HALF_E, `HALF_F, `HALF_G, `HALF_A, `HALF_B};
    mid = mids[$clog2(n.fields.key)];
    case (n.fields.oct)
        OCT_HIGH: return mid / 2;
        OCT_LOW:  return mid * 2;
        default:  return mid;
    endcase
endfunction

task automatic load_chart();
    for (int a = 0; a < `CHART_LEN; a++) begin
        @(posedge prog_clk);
        chart_wr_en   <= 1'b1;
        chart_wr_addr <= a[`CHART_AW-1:0];
        chart_wr_note <= chart[a];
    end
    @(posedge prog_clk);
    chart_wr_en <= 1'b0;
endtask

// Playing must stay low while the digit counts down
task automatic wait_digit_change(input logic [1:0] from, input int limit);
    int n;
    n = 0;
    while (count_digit === from) begin
        if (n == limit) begin
            fail_run("timeout: countdown digit did not change");
        end
        compare_bits("playing", 8'(playing), 8'h00);
        @(negedge prog_clk);
        n++;
    end
endtask

task automatic wait_playing(input int limit);
    int n;
    n = 0;
    while (playing !== 1'b1) begin
        if (n == limit) begin
            fail_run("timeout: playing never rose after the countdown");
        end
        compare_bits("count_digit", 8'(count_digit), 8'h00);
        @(negedge prog_clk);
        n++;
    end
endtask

task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (done !== 1'b1) begin
        if (n == limit) begin
            fail_run("timeout: done never rose after the last note");
        end
        @(negedge prog_clk);
        n++;
    end
endtask

`endif

// File: verif/game_tb.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module game_tb;
    import game_pkg::*;

    localparam int PLAY_LEN    = 10;
    localparam int PLAY_CYCLES = (PLAY_LEN + 2) * `STEP_CYCLES;
    localparam int DIGIT_WAIT  = `COUNT_STEPS * `STEP_CYCLES + 8;

    logic                 prog_clk;
    logic                 rst;
    logic                 chart_wr_en;
    logic [`CHART_AW-1:0] chart_wr_addr;
    note_t                chart_wr_note;
    logic [`CHART_AW:0]   chart_len;
    note_t                key_in;
    logic [1:0]           count_digit;
    logic                 playing;
    logic                 done;
    note_t                cur_note;
    score_t               score;
    logic                 tone;
    logic [7:0]           led;

    note_t  chart [`CHART_LEN];
    note_t  key_at [32];
    note_t  model_hist [3];
    score_t exp_score;

    `include "game_tb_tasks.svh"

    initial begin
        prog_clk = 1'b0;
        forever #50 prog_clk = ~prog_clk;
    end

    game_top i_dut (
        .prog_clk      (prog_clk),
        .rst           (rst),
        .chart_wr_en   (chart_wr_en),
        .chart_wr_addr (chart_wr_addr),
        .chart_wr_note (chart_wr_note),
        .chart_len     (chart_len),
        .key_in        (key_in),
        .count_digit   (count_digit),
        .playing       (playing),
        .done          (done),
        .cur_note      (cur_note),
        .score         (score),
        .tone          (tone),
        .led           (led)
    );

    // Expected cur_note c cycles after playing rose
    function automatic note_t note_at(input int c);
        int k;
        k = c / `STEP_CYCLES;
        if (c < 0 || k == 0) begin
            return '0;
        end
        return chart[(k > PLAY_LEN ? PLAY_LEN : k) - 1];
    endfunction

    // Earliest window position holding the note sets the points
    function automatic score_t points_for(input note_t want, input note_t now);
        note_t window [4];
        window[0] = now;
        window[1] = model_hist[0];
        window[2] = model_hist[1];
        window[3] = model_hist[2];
        for (int p = 0; p < 4; p++) begin
            if (is_playable(want) && window[p].raw == want.raw) begin
                return (p < 2) ? score_t'(`PTS_EXACT) :
                       (p == 2) ? score_t'(`PTS_NEAR) : score_t'(`PTS_LATE);
            end
        end
        return '0;
    endfunction

    // Every octave up front, a rest at entry 4, no equal neighbours
    task automatic build_chart();
        note_t n;
        for (int a = 0; a < `CHART_LEN; a++) begin
            do begin
                n.fields.oct = octave_t'($urandom_range(2));
                n.fields.key = 7'(1 << $urandom_range(6));
            end while (a > 0 && n.raw == chart[a - 1].raw);
            if (a < 3) begin
                n.fields.oct = octave_t'(a);
            end
            chart[a] = (a == 4) ? note_t'(9'h003) : n;
        end
    endtask

    // Per note in turn: miss, hold, press a sample early, press late
    task automatic plan_keys();
        foreach (key_at[s]) begin
            key_at[s] = '0;
        end
        for (int k = 1; k <= PLAY_LEN; k++) begin
            case ((k + 2) % 4)
                0: begin
                    key_at[2 * k + 1] = chart[k - 1];
                    key_at[2 * k + 2] = chart[k - 1];
                end
                1: key_at[2 * k - 1] = chart[k - 1];
                2: key_at[2 * k + 2] = chart[k - 1];
                default: ;
            endcase
        end
    endtask

    task automatic check_countdown();
        @(negedge prog_clk);
        compare_bits("count_digit", 8'(count_digit), 8'h03);
        for (int d = 2; d >= 0; d--) begin
            wait_digit_change(2'(d + 1), DIGIT_WAIT);
            compare_bits("count_digit", 8'(count_digit), 8'(d));
        end
        wait_playing(DIGIT_WAIT);
    endtask

    // Cycle by cycle from the rise of playing; notes, LEDs, tone and score
    task automatic run_playback();
        note_t gov;
        logic  last_tone;
        int    last_toggle;
        int    toggles;
        int    intervals;
        last_tone   = 1'b0;
        last_toggle = 0;
        toggles     = 0;
        intervals   = 0;
        for (int c = 0; c < PLAY_CYCLES; c++) begin
            gov = note_at(c - 1);
            compare_note("cur_note", cur_note, note_at(c));
            compare_bits("playing", 8'(playing), 8'h01);
            compare_bits("done", 8'(done), 8'(c >= PLAY_LEN * `STEP_CYCLES));
            compare_bits("led", led, led_rule(gov));
            compare_score("score", score, exp_score);
            if (gov.raw != note_at(c - 2).raw) begin
                if (is_playable(note_at(c - 2)) && intervals == 0) begin
                    fail_run("tone did not toggle twice during a note");
                end
                toggles   = 0;
                intervals = 0;
            end else if (!is_playable(gov)) begin
                compare_bits("tone", 8'(tone), 8'h00);
            end else if (tone !== last_tone) begin
                if (toggles > 0) begin
                    compare_bits("tone half-period", 8'(c - last_toggle), 8'(half_rule(gov)));
                    intervals++;
                end
                toggles++;
                last_toggle = c;
            end
            last_tone = tone;
            // Sample edge next; done still low means it counts
            if ((c + 1) % `SAMPLE_CYCLES == 0 && c < PLAY_LEN * `STEP_CYCLES) begin
                exp_score    += points_for(note_at(c), key_in);
                model_hist[2] = model_hist[1];
                model_hist[1] = model_hist[0];
                model_hist[0] = key_in;
            end
            @(posedge prog_clk);
            if ((c + 1) % `SAMPLE_CYCLES == 0) begin
                key_in <= key_at[(c + 1) / `SAMPLE_CYCLES + 1];
            end
            @(negedge prog_clk);
        end
    endtask

    task automatic check_final_score();
        wait_done(`STEP_CYCLES);
        compare_note("cur_note", cur_note, chart[PLAY_LEN - 1]);
        compare_score("score", score, exp_score);
    endtask

    initial begin
        int seed_ret;
        seed_ret      = $urandom(32'hd655);
        rst           <= 1'b1;
        chart_wr_en   <= 1'b0;
        chart_wr_addr <= '0;
        chart_wr_note <= '0;
        chart_len     <= (`CHART_AW + 1)'(PLAY_LEN);
        key_in        <= '0;
        exp_score     = '0;
        foreach (model_hist[i]) begin
            model_hist[i] = '0;
        end
        build_chart();
        plan_keys();
        repeat (16) @(posedge prog_clk);
        rst <= 1'b0;
        load_chart();
        check_countdown();
        run_playback();
        check_final_score();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
+incdir+verif
design/game_pkg.sv
design/chart_mem.sv
design/beat_timer.sv
design/note_sequencer.sv
design/hit_scorer.sv
design/note_output.sv
design/game_top.sv
verif/game_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module game_tb -f build.f -o game_sim

sim_out=$(./obj_dir/game_sim 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "^NO ERRORS$"; then
    exit 0
fi
exit 1
